/* logic/exec_pkg.sv */
package exec_pkg;

    // RV64 integer datapath widths.
    localparam int xlen           = 64;
    localparam int pc_width       = 48; // Zero-extended to xlen for auipc.
    localparam int reg_addr_width = 5;
    localparam int reg_count      = 32;

    localparam int alu_op_width   = 11;

    // One bit per operation, exactly one set for a valid instruction.
    typedef logic [alu_op_width-1:0] alu_op_t;

    localparam int op_add   = 0;
    localparam int op_slt   = 1;  // Unsigned when is_unsigned is set.
    localparam int op_xor   = 2;
    localparam int op_or    = 3;
    localparam int op_and   = 4;
    localparam int op_sll   = 5;
    localparam int op_srl   = 6;
    localparam int op_sra   = 7;
    localparam int op_sub   = 8;
    localparam int op_lui   = 9;
    localparam int op_auipc = 10;

endpackage

/* logic/alu.sv */
module alu (
    input  logic [exec_pkg::xlen-1:0]     src1,
    input  logic [exec_pkg::xlen-1:0]     src2,
    input  logic [exec_pkg::xlen-1:0]     imm,
    input  logic [exec_pkg::pc_width-1:0] pc,
    input  logic                          valid,
    input  exec_pkg::alu_op_t             alu_op,
    input  logic                          is_word,
    input  logic                          is_unsigned,
    input  logic                          is_imm,
    output logic [exec_pkg::xlen-1:0]     result
);
    import exec_pkg::*;

    logic            is_add;
    logic            is_slt;
    logic            is_xor;
    logic            is_or;
    logic            is_and;
    logic            is_sll;
    logic            is_srl;
    logic            is_sra;
    logic            is_sub;
    logic            is_lui;
    logic            is_auipc;

    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] addend;
    logic [xlen-1:0] sum;
    logic            less;
    logic [5:0]      shamt;
    logic [31:0]     sll_w;
    logic [31:0]     srl_w;
    logic [31:0]     sra_w;
    logic [xlen-1:0] sll_d;
    logic [xlen-1:0] srl_d;
    logic [xlen-1:0] sra_d;
    logic [xlen-1:0] raw_result;

    function automatic logic [xlen-1:0] sext_word(input logic [31:0] value);
        return {{(xlen - 32){value[31]}}, value};
    endfunction

    assign is_add   = alu_op[op_add];
    assign is_slt   = alu_op[op_slt];
    assign is_xor   = alu_op[op_xor];
    assign is_or    = alu_op[op_or];
    assign is_and   = alu_op[op_and];
    assign is_sll   = alu_op[op_sll];
    assign is_srl   = alu_op[op_srl];
    assign is_sra   = alu_op[op_sra];
    assign is_sub   = alu_op[op_sub];
    assign is_lui   = alu_op[op_lui];
    assign is_auipc = alu_op[op_auipc];

    assign op_a   = is_auipc ? {{(xlen - pc_width){1'b0}}, pc} : src1;
    assign op_b   = (is_imm | is_auipc) ? imm : src2;
    assign addend = is_sub ? (~op_b + 1'b1) : op_b; // Two's complement for sub.
    assign sum    = op_a + addend;

    always_comb begin
        if (is_unsigned) begin
            less = src1 < op_b;
        end else begin
            less = $signed(src1) < $signed(op_b);
        end
    end

    assign shamt = op_b[5:0]; // Word shifts take only bits 4:0.

    assign sll_w = src1[31:0] << shamt[4:0];
    assign srl_w = src1[31:0] >> shamt[4:0];
    assign sra_w = $signed(src1[31:0]) >>> shamt[4:0];

    assign sll_d = src1 << shamt;
    assign srl_d = src1 >> shamt;
    assign sra_d = $signed(src1) >>> shamt;

    always_comb begin
        raw_result = '0;
        // The low 32 bits of the full sum are the word sum.
        if (is_add | is_sub | is_auipc) begin
            raw_result = (is_word && !is_auipc) ? sext_word(sum[31:0]) : sum;
        end else if (is_slt) begin
            raw_result = {{(xlen - 1){1'b0}}, less};
        end else if (is_xor) begin
            raw_result = src1 ^ op_b;
        end else if (is_or) begin
            raw_result = src1 | op_b;
        end else if (is_and) begin
            raw_result = src1 & op_b;
        end else if (is_sll) begin
            raw_result = is_word ? sext_word(sll_w) : sll_d;
        end else if (is_srl) begin
            raw_result = is_word ? sext_word(srl_w) : srl_d;
        end else if (is_sra) begin
            raw_result = is_word ? sext_word(sra_w) : sra_d;
        end else if (is_lui) begin
            raw_result = imm; // Decode has already shifted the upper immediate.
        end
    end

    assign result = valid ? raw_result : '0;

endmodule

/* logic/int_regfile.sv */
module int_regfile (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_0,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_1,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_2,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_addr_3,
    output logic [exec_pkg::xlen-1:0]           rd_data_0,
    output logic [exec_pkg::xlen-1:0]           rd_data_1,
    output logic [exec_pkg::xlen-1:0]           rd_data_2,
    output logic [exec_pkg::xlen-1:0]           rd_data_3,
    input  logic                                wr_en_0,
    input  logic [exec_pkg::reg_addr_width-1:0] wr_addr_0,
    input  logic [exec_pkg::xlen-1:0]           wr_data_0,
    input  logic                                wr_en_1,
    input  logic [exec_pkg::reg_addr_width-1:0] wr_addr_1,
    input  logic [exec_pkg::xlen-1:0]           wr_data_1
);
    import exec_pkg::*;

    logic [xlen-1:0] regs [reg_count];

    // Write-through read. Port 1 is the younger write and takes priority.
    function automatic logic [xlen-1:0] read_port(input logic [reg_addr_width-1:0] addr);
        logic [xlen-1:0] data;
        data = regs[addr];
        if (wr_en_0 && wr_addr_0 == addr) begin
            data = wr_data_0;
        end
        if (wr_en_1 && wr_addr_1 == addr) begin
            data = wr_data_1;
        end
        return data;
    endfunction

    always_comb begin
        rd_data_0 = read_port(rd_addr_0);
        rd_data_1 = read_port(rd_addr_1);
        rd_data_2 = read_port(rd_addr_2);
        rd_data_3 = read_port(rd_addr_3);
    end

    // x0 stays zero since the writeback stage never targets it.
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < reg_count; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (wr_en_0) begin
                regs[wr_addr_0] <= wr_data_0;
            end
            if (wr_en_1) begin
                regs[wr_addr_1] <= wr_data_1;
            end
        end
    end

endmodule

/* logic/wb_merge.sv */
module wb_merge (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                valid_0,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_0,
    input  logic [exec_pkg::xlen-1:0]           result_0,
    input  logic                                valid_1,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_1,
    input  logic [exec_pkg::xlen-1:0]           result_1,
    output logic                                wb_valid_0,
    output logic [exec_pkg::reg_addr_width-1:0] wb_rd_0,
    output logic [exec_pkg::xlen-1:0]           wb_data_0,
    output logic                                wb_valid_1,
    output logic [exec_pkg::reg_addr_width-1:0] wb_rd_1,
    output logic [exec_pkg::xlen-1:0]           wb_data_1
);

    logic write_0;
    logic write_1;
    logic same_rd;

    assign same_rd = valid_1 && (rd_0 == rd_1);

    // Lane 1 is younger, so a shared destination keeps only its result.
    assign write_0 = valid_0 && (rd_0 != '0) && !same_rd;
    assign write_1 = valid_1 && (rd_1 != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid_0 <= 1'b0;
            wb_valid_1 <= 1'b0;
        end else begin
            wb_valid_0 <= write_0;
            wb_valid_1 <= write_1;
        end
    end

    always_ff @(posedge clk) begin
        if (write_0) begin
            wb_rd_0   <= rd_0;
            wb_data_0 <= result_0;
        end
        if (write_1) begin
            wb_rd_1   <= rd_1;
            wb_data_1 <= result_1;
        end
    end

endmodule

/* logic/exec_cluster.sv */
module exec_cluster (
    input  logic                                clk,
    input  logic                                reset,

    input  logic                                issue_valid_0,
    input  exec_pkg::alu_op_t                   alu_op_0,
    input  logic                                is_word_0,
    input  logic                                is_unsigned_0,
    input  logic                                is_imm_0,
    input  logic [exec_pkg::reg_addr_width-1:0] rs1_0,
    input  logic [exec_pkg::reg_addr_width-1:0] rs2_0,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_0,
    input  logic [exec_pkg::xlen-1:0]           imm_0,
    input  logic [exec_pkg::pc_width-1:0]       pc_0,

    input  logic                                issue_valid_1,
    input  exec_pkg::alu_op_t                   alu_op_1,
    input  logic                                is_word_1,
    input  logic                                is_unsigned_1,
    input  logic                                is_imm_1,
    input  logic [exec_pkg::reg_addr_width-1:0] rs1_1,
    input  logic [exec_pkg::reg_addr_width-1:0] rs2_1,
    input  logic [exec_pkg::reg_addr_width-1:0] rd_1,
    input  logic [exec_pkg::xlen-1:0]           imm_1,
    input  logic [exec_pkg::pc_width-1:0]       pc_1,

    output logic                                wb_valid_0,
    output logic [exec_pkg::reg_addr_width-1:0] wb_rd_0,
    output logic [exec_pkg::xlen-1:0]           wb_data_0,
    output logic                                wb_valid_1,
    output logic [exec_pkg::reg_addr_width-1:0] wb_rd_1,
    output logic [exec_pkg::xlen-1:0]           wb_data_1
);
    import exec_pkg::*;

    logic [xlen-1:0] rs1_data_0;
    logic [xlen-1:0] rs2_data_0;
    logic [xlen-1:0] rs1_data_1;
    logic [xlen-1:0] rs2_data_1;
    logic [xlen-1:0] alu_result_0;
    logic [xlen-1:0] alu_result_1;

    // Writeback ports double as the register file write ports.
    int_regfile u_regfile (
        .clk       (clk),
        .reset     (reset),
        .rd_addr_0 (rs1_0),
        .rd_addr_1 (rs2_0),
        .rd_addr_2 (rs1_1),
        .rd_addr_3 (rs2_1),
        .rd_data_0 (rs1_data_0),
        .rd_data_1 (rs2_data_0),
        .rd_data_2 (rs1_data_1),
        .rd_data_3 (rs2_data_1),
        .wr_en_0   (wb_valid_0),
        .wr_addr_0 (wb_rd_0),
        .wr_data_0 (wb_data_0),
        .wr_en_1   (wb_valid_1),
        .wr_addr_1 (wb_rd_1),
        .wr_data_1 (wb_data_1)
    );

    alu u_alu_0 (
        .src1        (rs1_data_0),
        .src2        (rs2_data_0),
        .imm         (imm_0),
        .pc          (pc_0),
        .valid       (issue_valid_0),
        .alu_op      (alu_op_0),
        .is_word     (is_word_0),
        .is_unsigned (is_unsigned_0),
        .is_imm      (is_imm_0),
        .result      (alu_result_0)
    );

    alu u_alu_1 (
        .src1        (rs1_data_1),
        .src2        (rs2_data_1),
        .imm         (imm_1),
        .pc          (pc_1),
        .valid       (issue_valid_1),
        .alu_op      (alu_op_1),
        .is_word     (is_word_1),
        .is_unsigned (is_unsigned_1),
        .is_imm      (is_imm_1),
        .result      (alu_result_1)
    );

    wb_merge u_wb_merge (
        .clk        (clk),
        .reset      (reset),
        .valid_0    (issue_valid_0),
        .rd_0       (rd_0),
        .result_0   (alu_result_0),
        .valid_1    (issue_valid_1),
        .rd_1       (rd_1),
        .result_1   (alu_result_1),
        .wb_valid_0 (wb_valid_0),
        .wb_rd_0    (wb_rd_0),
        .wb_data_0  (wb_data_0),
        .wb_valid_1 (wb_valid_1),
        .wb_rd_1    (wb_rd_1),
        .wb_data_1  (wb_data_1)
    );

endmodule

/* tb/exec_cluster_chk.sv */
module exec_cluster_chk (
    input logic                                clk,
    input logic                                reset,
    input logic                                wb_valid_0,
    input logic [exec_pkg::reg_addr_width-1:0] wb_rd_0,
    input logic                                wb_valid_1,
    input logic [exec_pkg::reg_addr_width-1:0] wb_rd_1
);

    // Reset clears both writeback strobes by the following edge.
    reset_clears_valid: assert property (@(posedge clk) reset |=> !wb_valid_0 && !wb_valid_1)
        else $error("writeback valid in the cycle after reset");

    no_x0_write_0: assert property (@(posedge clk) disable iff (reset) wb_valid_0 |-> wb_rd_0 != '0)
        else $error("lane 0 writeback targets x0");

    no_x0_write_1: assert property (@(posedge clk) disable iff (reset) wb_valid_1 |-> wb_rd_1 != '0)
        else $error("lane 1 writeback targets x0");

    // The merge must never leave two writes to one register.
    no_shared_rd: assert property (@(posedge clk) disable iff (reset)
        !(wb_valid_0 && wb_valid_1 && wb_rd_0 == wb_rd_1))
        else $error("both writebacks target the same register");

endmodule

bind wb_merge exec_cluster_chk u_chk (
    .clk        (clk),
    .reset      (reset),
    .wb_valid_0 (wb_valid_0),
    .wb_rd_0    (wb_rd_0),
    .wb_valid_1 (wb_valid_1),
    .wb_rd_1    (wb_rd_1)
);

/* tb/exec_cluster_tb.sv */
module exec_cluster_tb;
    import exec_pkg::*;

    localparam int drive_delay   = 10;
    localparam int reset_timeout = 20;
    localparam int random_cycles = 600;

    // Field order matches the DUT lane ports in the assigns below.
    typedef struct packed {
        logic                      valid;
        alu_op_t                   op;
        logic                      word;
        logic                      uns;
        logic                      imm_form;
        logic [reg_addr_width-1:0] rs1;
        logic [reg_addr_width-1:0] rs2;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           imm;
        logic [pc_width-1:0]       pc;
    } lane_t;

    typedef struct packed {
        logic                      valid;
        logic [reg_addr_width-1:0] rd;
        logic [xlen-1:0]           data;
    } wb_t;

    logic                      clk = 1'b0;
    logic                      reset = 1'b1;
    logic                      issue_valid_0, is_word_0, is_unsigned_0, is_imm_0;
    logic                      issue_valid_1, is_word_1, is_unsigned_1, is_imm_1;
    alu_op_t                   alu_op_0, alu_op_1;
    logic [reg_addr_width-1:0] rs1_0, rs2_0, rd_0, rs1_1, rs2_1, rd_1;
    logic [xlen-1:0]           imm_0, imm_1;
    logic [pc_width-1:0]       pc_0, pc_1;
    logic                      wb_valid_0, wb_valid_1;
    logic [reg_addr_width-1:0] wb_rd_0, wb_rd_1;
    logic [xlen-1:0]           wb_data_0, wb_data_1;

    lane_t           lane [2];
    logic [xlen-1:0] model_regs [reg_count];
    wb_t             expect_q [$]; // Two entries per issue cycle, lane 0 first.
    int              error_count = 0;
    int              timeout_count = 0;

    assign {issue_valid_0, alu_op_0, is_word_0, is_unsigned_0, is_imm_0, rs1_0, rs2_0, rd_0,
            imm_0, pc_0} = lane[0];
    assign {issue_valid_1, alu_op_1, is_word_1, is_unsigned_1, is_imm_1, rs1_1, rs2_1, rd_1,
            imm_1, pc_1} = lane[1];

    exec_cluster DUT (.*);

    always #50 clk = ~clk;

    initial begin
        repeat (3) @(posedge clk);
        #drive_delay;
        reset = 1'b0;
    end

    function automatic logic [xlen-1:0] sign_extend_word(input logic [31:0] value);
        return {{(xlen - 32){value[31]}}, value};
    endfunction

    function automatic logic [xlen-1:0] expected_result(input lane_t ins,
                                                         input logic [xlen-1:0] a,
                                                         input logic [xlen-1:0] b);
        logic [xlen-1:0] second;
        logic [xlen-1:0] sra_full;
        logic [xlen-1:0] result;
        logic            less;
        second   = (ins.imm_form || ins.op[op_auipc]) ? ins.imm : b;
        sra_full = $signed(a) >>> second[5:0];
        less     = ins.uns ? (a < second) : ($signed(a) < $signed(second));
        case (1'b1)
            ins.op[op_add]:   result = ins.word ? sign_extend_word(a[31:0] + second[31:0])
                                                : a + second;
            ins.op[op_sub]:   result = ins.word ? sign_extend_word(a[31:0] - second[31:0])
                                                : a - second;
            ins.op[op_slt]:   result = {{(xlen - 1){1'b0}}, less};
            ins.op[op_xor]:   result = a ^ second;
            ins.op[op_or]:    result = a | second;
            ins.op[op_and]:   result = a & second;
            ins.op[op_sll]:   result = ins.word ? sign_extend_word(a[31:0] << second[4:0])
                                                : a << second[5:0];
            ins.op[op_srl]:   result = ins.word ? sign_extend_word(a[31:0] >> second[4:0])
                                                : a >> second[5:0];
            ins.op[op_sra]:   result = ins.word ? sign_extend_word($signed(a[31:0]) >>> second[4:0])
                                                : sra_full;
            ins.op[op_lui]:   result = ins.imm;
            ins.op[op_auipc]: result = {{(xlen - pc_width){1'b0}}, ins.pc} + ins.imm;
            default:          result = '0;
        endcase
        return result;
    endfunction

    task automatic check_value(input string name, input logic [xlen-1:0] actual,
                               input logic [xlen-1:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s is 0x%h, expected 0x%h at %0t", name, actual, expected, $time);
        end
    endtask

    task automatic set_lane(input int l, input int op_index, input logic word, input logic uns,
                            input logic imm_form, input int rs1, input int rs2, input int rd,
                            input logic [xlen-1:0] imm);
        alu_op_t op;
        op           = '0;
        op[op_index] = 1'b1;
        lane[l] = {1'b1, op, word, uns, imm_form, rs1[reg_addr_width-1:0],
                   rs2[reg_addr_width-1:0], rd[reg_addr_width-1:0], imm,
                   pc_width'({$urandom, $urandom})};
    endtask

    task automatic random_lane(input int l);
        int   op_index;
        logic word;
        op_index = $urandom_range(alu_op_width - 1, 0);
        word     = 1'b0;
        if (op_index inside {op_add, op_sub, op_sll, op_srl, op_sra}) begin
            word = 1'($urandom_range(1, 0));
        end
        set_lane(l, op_index, word, 1'($urandom_range(1, 0)), $urandom_range(3, 0) == 0,
                 $urandom_range(31, 0), $urandom_range(31, 0), $urandom_range(31, 0),
                 {$urandom, $urandom});
    endtask

    task automatic compare_writeback();
        wb_t expected;
        if (expect_q.size() < 2) begin
            return;
        end
        for (int l = 0; l < 2; l++) begin
            expected = expect_q.pop_front();
            check_value($sformatf("wb_valid_%0d", l), xlen'(l == 0 ? wb_valid_0 : wb_valid_1),
                        xlen'(expected.valid));
            if (expected.valid) begin
                check_value($sformatf("wb_rd_%0d", l), xlen'(l == 0 ? wb_rd_0 : wb_rd_1),
                            xlen'(expected.rd));
                check_value($sformatf("wb_data_%0d", l), l == 0 ? wb_data_0 : wb_data_1,
                            expected.data);
            end
        end
    endtask

    // Outputs settle at the edge, so they are checked before the next pair is driven.
    task automatic next_cycle();
        @(posedge clk);
        #drive_delay;
        compare_writeback();
    endtask

    // Both lanes read the state before this cycle, then the writes are applied.
    task automatic commit_issue();
        wb_t             wb [2];
        logic [xlen-1:0] result;
        for (int l = 0; l < 2; l++) begin
            result = expected_result(lane[l], model_regs[lane[l].rs1], model_regs[lane[l].rs2]);
            wb[l]  = {lane[l].valid && lane[l].rd != '0, lane[l].rd, result};
        end
        if (lane[0].valid && lane[1].valid && lane[0].rd == lane[1].rd) begin
            wb[0].valid = 1'b0; // Lane 1 is younger.
        end
        for (int l = 0; l < 2; l++) begin
            expect_q.push_back(wb[l]);
            if (wb[l].valid) begin
                model_regs[wb[l].rd] = wb[l].data;
            end
        end
    endtask

    // Polled at the falling edge, so the strobes of the last reset edge are still on view.
    task automatic wait_reset_release();
        int cycles;
        cycles = 0;
        while (reset && cycles < reset_timeout) begin
            @(negedge clk);
            cycles++;
        end
        if (reset) begin
            timeout_count++;
            $display("Timeout: reset still asserted after %0d cycles", reset_timeout);
        end
    endtask

    task automatic run_directed();
        // Each register read through an add with x0. Lane 1 targets x0 and writes nothing.
        for (int r = 1; r < reg_count; r++) begin
            next_cycle();
            set_lane(0, op_add, 1'b0, 1'b0, 1'b0, r, 0, r, '0);
            set_lane(1, op_add, 1'b0, 1'b0, 1'b0, 0, r, 0, '0);
            commit_issue();
        end
        next_cycle();
        set_lane(0, op_lui, 1'b0, 1'b0, 1'b0, 0, 0, 5, 64'h8000_0000_0000_0001);
        set_lane(1, op_add, 1'b0, 1'b0, 1'b0, 5, 0, 6, '0); // Sees the old x5.
        commit_issue();
        next_cycle();
        set_lane(0, op_slt, 1'b0, 1'b1, 1'b1, 5, 0, 7, 64'h1);
        set_lane(1, op_slt, 1'b0, 1'b0, 1'b1, 5, 0, 8, 64'h1);
        commit_issue();
        next_cycle();
        set_lane(0, op_add, 1'b1, 1'b0, 1'b1, 5, 0, 9, 64'h7fff_ffff);
        set_lane(1, op_lui, 1'b0, 1'b0, 1'b0, 0, 0, 9, 64'h1234_5000);
        commit_issue();
        next_cycle();
        set_lane(0, op_add, 1'b0, 1'b0, 1'b0, 9, 0, 10, '0);
        set_lane(1, op_sll, 1'b1, 1'b0, 1'b1, 5, 0, 11, 64'd31);
        commit_issue();
    endtask

    task automatic run_random();
        for (int i = 0; i < random_cycles; i++) begin
            next_cycle();
            random_lane(0);
            random_lane(1);
            if ($urandom_range(7, 0) == 0) begin
                lane[1].rd = lane[0].rd;
            end
            if ($urandom_range(15, 0) == 0) begin
                lane[$urandom_range(1, 0)] = '0;
            end
            commit_issue();
        end
    endtask

    initial begin
        void'($urandom(54));
        for (int r = 0; r < reg_count; r++) begin
            model_regs[r] = '0;
        end
        // Both lanes hold valid adds through reset, which must keep them off writeback.
        set_lane(0, op_add, 1'b0, 1'b0, 1'b0, 0, 0, 1, '0);
        set_lane(1, op_add, 1'b0, 1'b0, 1'b0, 0, 0, 2, '0);
        wait_reset_release();
        if (timeout_count == 0) begin
            check_value("wb_valid_0", xlen'(wb_valid_0), '0);
            check_value("wb_valid_1", xlen'(wb_valid_1), '0);
            commit_issue(); // The held pair is taken at the first edge after reset.
            run_directed();
            run_random();
            next_cycle();
            lane[0] = '0;
            lane[1] = '0;
        end
        $display("Errors: %0d mismatches, %0d timeouts", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* exec_cluster.f */
logic/exec_pkg.sv
logic/alu.sv
logic/int_regfile.sv
logic/wb_merge.sv
logic/exec_cluster.sv
tb/exec_cluster_chk.sv
tb/exec_cluster_tb.sv

/* run_sim.sh */
#!/bin/bash
# Builds the execute cluster testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module exec_cluster_tb \
    -f exec_cluster.f -o exec_cluster_sim > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/exec_cluster_sim > sim.log 2>&1
cat sim.log

grep -q "sim failed" sim.log && { echo "Simulation reported a failure"; exit 1; }
grep -q "sim passed" sim.log || { echo "Simulation ended without a result"; exit 1; }
echo "Simulation finished cleanly"
